// File: common/gnn_config.svh
`ifndef GNN_CONFIG_SVH
`define GNN_CONFIG_SVH

// graph size
`define GNN_NUM_NODES   8
`define GNN_FEAT_DIM    4
`define GNN_NODE_AW     3

// node watched by the debug monitor
`define GNN_PROBE_NODE  5

// output saturation ceiling
`define GNN_OUT_MAX     32767

`endif

// File: common/gnn_pkg.sv
`include "gnn_config.svh"

package gnn_pkg;

  // one signed feature or weight lane
  typedef logic signed [7:0] lane_t;

  // lane 0 sits in bits [7:0]
  typedef lane_t [`GNN_FEAT_DIM-1:0] feat_vec_t;

  // bit j set: node j is a neighbour
  typedef logic [`GNN_NUM_NODES-1:0] adj_t;

  typedef logic signed [17:0] hid_t;  // projection result
  typedef logic [15:0] out_t;         // relu'd and saturated

  typedef logic [`GNN_NODE_AW-1:0] node_idx_t;

  // host write target
  typedef enum logic [1:0] {
    WR_FEAT = 2'd0,
    WR_ADJ  = 2'd1,
    WR_WGT  = 2'd2
  } wr_sel_e;

endpackage

// File: common/stage_ctl_if.sv
`timescale 1ns/1ps

// one-cycle start/done strobes between the scheduler and the stages
interface stage_ctl_if;

  logic dmvm_start;
  logic dmvm_done;
  logic spmm_start;
  logic spmm_done;

  modport sched (output dmvm_start, output spmm_start,
                 input  dmvm_done,  input  spmm_done);

  modport dmvm (input dmvm_start, output dmvm_done);

  modport spmm (input spmm_start, output spmm_done);

  modport mon (input dmvm_start, input dmvm_done,
               input spmm_start, input spmm_done);

endinterface

// File: source/node_ram.sv
`timescale 1ns/1ps

module node_ram #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  T                         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output T                         rdata_o
);

  T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    rdata_o <= mem[raddr_i];  // old data on a same-address write
  end

endmodule

// File: source/gat_scheduler.sv
`timescale 1ns/1ps

module gat_scheduler (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start_i,
  stage_ctl_if.sched ctl,
  output logic       busy_o,
  output logic       done_o
);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    DMVM = 2'd1,
    SPMM = 2'd2
  } state_e;

  state_e state_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= IDLE;
      ctl.dmvm_start <= 1'b0;
      ctl.spmm_start <= 1'b0;
      done_o         <= 1'b0;
    end else begin
      // strobes default low, so each is one cycle wide
      ctl.dmvm_start <= 1'b0;
      ctl.spmm_start <= 1'b0;
      done_o         <= 1'b0;

      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q        <= DMVM;
            ctl.dmvm_start <= 1'b1;
          end
        end

        DMVM: begin
          if (ctl.dmvm_done) begin
            state_q        <= SPMM;
            ctl.spmm_start <= 1'b1;  // handover the cycle after dmvm_done
          end
        end

        SPMM: begin
          if (ctl.spmm_done) begin
            state_q <= IDLE;
            done_o  <= 1'b1;
          end
        end

        default: state_q <= IDLE;
      endcase
    end
  end

  // rises with dmvm_start, falls with done_o
  assign busy_o = (state_q != IDLE);

endmodule

// File: dmvm/dmvm_unit.sv
`timescale 1ns/1ps
`include "gnn_config.svh"

module dmvm_unit (
  input  logic               clk,
  input  logic               rst_n,
  stage_ctl_if.dmvm          ctl,
  input  logic               wgt_we_i,
  input  gnn_pkg::feat_vec_t wgt_i,
  output gnn_pkg::node_idx_t feat_raddr_o,
  input  gnn_pkg::feat_vec_t feat_rdata_i,
  output logic               hid_we_o,
  output gnn_pkg::node_idx_t hid_waddr_o,
  output gnn_pkg::hid_t      hid_wdata_o
);

  localparam gnn_pkg::node_idx_t LAST_NODE = gnn_pkg::node_idx_t'(`GNN_NUM_NODES - 1);

  gnn_pkg::feat_vec_t wgt_q;
  gnn_pkg::node_idx_t rd_cnt;
  logic               rd_act;
  logic               pend_vld;   // feature data arrives this cycle
  gnn_pkg::node_idx_t pend_addr;
  gnn_pkg::hid_t      dot;

  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_q <= wgt_i;
    end
    pend_addr <= rd_cnt;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_act        <= 1'b0;
      rd_cnt        <= '0;
      pend_vld      <= 1'b0;
      ctl.dmvm_done <= 1'b0;
    end else begin
      pend_vld      <= rd_act;
      ctl.dmvm_done <= pend_vld && (pend_addr == LAST_NODE);  // after the last write
      if (ctl.dmvm_start) begin
        rd_act <= 1'b1;
        rd_cnt <= '0;
      end else if (rd_act) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == LAST_NODE) begin
          rd_act <= 1'b0;
        end
      end
    end
  end

  // 8x8 products fit in 16 bits, four of them in 18
  always_comb begin
    dot = '0;
    for (int i = 0; i < `GNN_FEAT_DIM; i++) begin
      dot = dot + gnn_pkg::hid_t'($signed(feat_rdata_i[i]) * $signed(wgt_q[i]));
    end
  end

  assign feat_raddr_o = rd_cnt;
  assign hid_we_o     = pend_vld;
  assign hid_waddr_o  = pend_addr;
  assign hid_wdata_o  = dot;

endmodule

// File: spmm/spmm_unit.sv
`timescale 1ns/1ps
`include "gnn_config.svh"

module spmm_unit (
  input  logic               clk,
  input  logic               rst_n,
  stage_ctl_if.spmm          ctl,
  output gnn_pkg::node_idx_t adj_raddr_o,
  input  gnn_pkg::adj_t      adj_rdata_i,
  output gnn_pkg::node_idx_t hid_raddr_o,
  input  gnn_pkg::hid_t      hid_rdata_i,
  output logic               out_vld_o,
  output gnn_pkg::node_idx_t out_node_o,
  output gnn_pkg::out_t      out_data_o
);

  localparam gnn_pkg::node_idx_t LAST_NODE = gnn_pkg::node_idx_t'(`GNN_NUM_NODES - 1);

  // per node: one mask cycle, eight hidden reads, one drain cycle
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_MASK  = 3'd1,
    ST_HID   = 3'd2,
    ST_DRAIN = 3'd3,
    ST_FIN   = 3'd4
  } step_e;

  step_e              step_q;
  gnn_pkg::node_idx_t node_cnt;
  gnn_pkg::node_idx_t nb_cnt;
  gnn_pkg::node_idx_t rd_nb;     // neighbour whose hidden value is on the bus
  logic               rd_vld;
  logic signed [20:0] acc_q;
  logic signed [20:0] acc_nxt;
  gnn_pkg::out_t      sat;

  // address held for the whole node, so the mask stays valid on the read port
  assign adj_raddr_o = node_cnt;
  assign hid_raddr_o = nb_cnt;

  always_comb begin
    acc_nxt = acc_q;
    if (rd_vld && adj_rdata_i[rd_nb]) begin
      acc_nxt = acc_q + $signed({{3{hid_rdata_i[17]}}, hid_rdata_i});
    end
    if (acc_nxt < 0) begin
      sat = '0;  // relu
    end else if (acc_nxt > `GNN_OUT_MAX) begin
      sat = gnn_pkg::out_t'(`GNN_OUT_MAX);
    end else begin
      sat = gnn_pkg::out_t'(acc_nxt);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q        <= ST_IDLE;
      node_cnt      <= '0;
      nb_cnt        <= '0;
      rd_vld        <= 1'b0;
      out_vld_o     <= 1'b0;
      ctl.spmm_done <= 1'b0;
    end else begin
      rd_vld        <= (step_q == ST_HID);
      out_vld_o     <= 1'b0;
      ctl.spmm_done <= 1'b0;
      case (step_q)
        ST_IDLE: begin
          if (ctl.spmm_start) begin
            node_cnt <= '0;
            step_q   <= ST_MASK;
          end
        end
        ST_MASK: begin
          nb_cnt <= '0;
          step_q <= ST_HID;
        end
        ST_HID: begin
          nb_cnt <= nb_cnt + 1'b1;
          if (nb_cnt == LAST_NODE) step_q <= ST_DRAIN;
        end
        ST_DRAIN: begin
          out_vld_o <= 1'b1;  // last term folds in through acc_nxt
          if (node_cnt == LAST_NODE) begin
            step_q <= ST_FIN;
          end else begin
            node_cnt <= node_cnt + 1'b1;
            step_q   <= ST_MASK;
          end
        end
        ST_FIN: begin
          ctl.spmm_done <= 1'b1;
          step_q        <= ST_IDLE;
        end
        default: step_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    rd_nb <= nb_cnt;
    acc_q <= (step_q == ST_MASK) ? '0 : acc_nxt;
    if (step_q == ST_DRAIN) begin
      out_node_o <= node_cnt;
      out_data_o <= sat;
    end
  end

endmodule

// File: source/gnn_debugger.sv
`timescale 1ns/1ps
`include "gnn_config.svh"

module gnn_debugger (
  input  logic               clk,
  input  logic               rst_n,
  stage_ctl_if.mon           ctl,
  input  logic               hid_we_i,
  input  gnn_pkg::node_idx_t hid_waddr_i,
  input  gnn_pkg::hid_t      hid_wdata_i,
  input  logic               out_vld_i,
  input  gnn_pkg::node_idx_t out_node_i,
  input  gnn_pkg::out_t      out_data_i,
  output logic [3:0]         flags_o,
  output logic [15:0]        count_o,
  output gnn_pkg::hid_t      probe_hid_o,
  output gnn_pkg::out_t      probe_out_o
);

  localparam gnn_pkg::node_idx_t PROBE = gnn_pkg::node_idx_t'(`GNN_PROBE_NODE);

  logic [3:0] strobes;

  // msb first: dmvm start, dmvm done, spmm start, spmm done
  assign strobes = {ctl.dmvm_start, ctl.dmvm_done, ctl.spmm_start, ctl.spmm_done};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_o     <= '0;
      count_o     <= '0;
      probe_hid_o <= '0;
      probe_out_o <= '0;
    end else begin
      flags_o <= flags_o | strobes;  // sticky until reset
      if (out_vld_i) begin
        count_o <= count_o + 16'd1;
      end
      if (hid_we_i && (hid_waddr_i == PROBE)) begin
        probe_hid_o <= hid_wdata_i;
      end
      if (out_vld_i && (out_node_i == PROBE)) begin
        probe_out_o <= out_data_i;
      end
    end
  end

endmodule

// File: source/gat_core.sv
`timescale 1ns/1ps
`include "gnn_config.svh"

module gat_core (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  logic        wr_en_i,
  input  logic [1:0]  wr_sel_i,
  input  logic [2:0]  wr_addr_i,
  input  logic [31:0] wr_data_i,
  output logic        busy_o,
  output logic        done_o,
  output logic        out_vld_o,
  output logic [2:0]  out_node_o,
  output logic [15:0] out_data_o,
  output logic [3:0]  dbg_flags_o,
  output logic [15:0] dbg_count_o,
  output logic [17:0] dbg_hid_o,
  output logic [15:0] dbg_out_o
);

  stage_ctl_if ctl_if ();

  gnn_pkg::wr_sel_e   wr_sel;
  logic               feat_we;
  logic               adj_we;
  logic               wgt_we;

  gnn_pkg::node_idx_t feat_raddr;
  gnn_pkg::feat_vec_t feat_rdata;
  gnn_pkg::node_idx_t adj_raddr;
  gnn_pkg::adj_t      adj_rdata;
  logic               hid_we;
  gnn_pkg::node_idx_t hid_waddr;
  gnn_pkg::hid_t      hid_wdata;
  gnn_pkg::node_idx_t hid_raddr;
  gnn_pkg::hid_t      hid_rdata;

  // host write decode, weight writes ignore the address
  assign wr_sel  = gnn_pkg::wr_sel_e'(wr_sel_i);
  assign feat_we = wr_en_i && (wr_sel == gnn_pkg::WR_FEAT);
  assign adj_we  = wr_en_i && (wr_sel == gnn_pkg::WR_ADJ);
  assign wgt_we  = wr_en_i && (wr_sel == gnn_pkg::WR_WGT);

  gat_scheduler u_sched (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start_i),
    .ctl     (ctl_if.sched),
    .busy_o  (busy_o),
    .done_o  (done_o)
  );

  node_ram #(.T(gnn_pkg::feat_vec_t), .DEPTH(`GNN_NUM_NODES)) u_feat_ram (
    .clk     (clk),
    .we_i    (feat_we),
    .waddr_i (wr_addr_i),
    .wdata_i (gnn_pkg::feat_vec_t'(wr_data_i)),
    .raddr_i (feat_raddr),
    .rdata_o (feat_rdata)
  );

  node_ram #(.T(gnn_pkg::adj_t), .DEPTH(`GNN_NUM_NODES)) u_adj_ram (
    .clk     (clk),
    .we_i    (adj_we),
    .waddr_i (wr_addr_i),
    .wdata_i (gnn_pkg::adj_t'(wr_data_i[`GNN_NUM_NODES-1:0])),
    .raddr_i (adj_raddr),
    .rdata_o (adj_rdata)
  );

  node_ram #(.T(gnn_pkg::hid_t), .DEPTH(`GNN_NUM_NODES)) u_hid_ram (
    .clk     (clk),
    .we_i    (hid_we),
    .waddr_i (hid_waddr),
    .wdata_i (hid_wdata),
    .raddr_i (hid_raddr),
    .rdata_o (hid_rdata)
  );

  dmvm_unit u_dmvm (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctl          (ctl_if.dmvm),
    .wgt_we_i     (wgt_we),
    .wgt_i        (gnn_pkg::feat_vec_t'(wr_data_i)),
    .feat_raddr_o (feat_raddr),
    .feat_rdata_i (feat_rdata),
    .hid_we_o     (hid_we),
    .hid_waddr_o  (hid_waddr),
    .hid_wdata_o  (hid_wdata)
  );

  spmm_unit u_spmm (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctl         (ctl_if.spmm),
    .adj_raddr_o (adj_raddr),
    .adj_rdata_i (adj_rdata),
    .hid_raddr_o (hid_raddr),
    .hid_rdata_i (hid_rdata),
    .out_vld_o   (out_vld_o),
    .out_node_o  (out_node_o),
    .out_data_o  (out_data_o)
  );

  gnn_debugger u_dbg (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctl         (ctl_if.mon),
    .hid_we_i    (hid_we),
    .hid_waddr_i (hid_waddr),
    .hid_wdata_i (hid_wdata),
    .out_vld_i   (out_vld_o),
    .out_node_i  (out_node_o),
    .out_data_i  (out_data_o),
    .flags_o     (dbg_flags_o),
    .count_o     (dbg_count_o),
    .probe_hid_o (dbg_hid_o),
    .probe_out_o (dbg_out_o)
  );

endmodule

// File: dv/gat_checker.sv
`timescale 1ns/1ps
`include "gnn_config.svh"

module gat_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr_en_i,
  input  logic [1:0]  wr_sel_i,
  input  logic [2:0]  wr_addr_i,
  input  logic [31:0] wr_data_i,
  input  logic        out_vld_i,
  input  logic [2:0]  out_node_i,
  input  logic [15:0] out_data_i,
  input  logic        done_i,
  input  logic [17:0] dbg_hid_i,
  input  logic [15:0] dbg_out_i,
  output int          err_cnt_o,
  output int          run_cnt_o
);

  gnn_pkg::feat_vec_t feat_mem [`GNN_NUM_NODES];
  gnn_pkg::adj_t      adj_mem [`GNN_NUM_NODES];
  gnn_pkg::feat_vec_t wgt_vec;
  int                 exp_node;
  int                 exp_val;

  // shadow copies of the host writes
  always @(posedge clk) begin
    if (wr_en_i) begin
      if (wr_sel_i == gnn_pkg::WR_FEAT) begin
        feat_mem[wr_addr_i] <= wr_data_i;
      end else if (wr_sel_i == gnn_pkg::WR_ADJ) begin
        adj_mem[wr_addr_i] <= wr_data_i[`GNN_NUM_NODES-1:0];
      end else if (wr_sel_i == gnn_pkg::WR_WGT) begin
        wgt_vec <= wr_data_i;  // address ignored
      end
    end
  end

  function automatic int ref_projection(input int node);
    int sum;
    sum = 0;
    for (int i = 0; i < `GNN_FEAT_DIM; i++) begin
      sum += int'(feat_mem[node][i]) * int'(wgt_vec[i]);
    end
    return sum;
  endfunction

  // neighbour sum, then relu and clamp
  function automatic int ref_output(input int node);
    int acc;
    acc = 0;
    for (int j = 0; j < `GNN_NUM_NODES; j++) begin
      if (adj_mem[node][j]) acc += ref_projection(j);
    end
    if (acc < 0) acc = 0;
    else if (acc > `GNN_OUT_MAX) acc = `GNN_OUT_MAX;
    return acc;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_cnt_o = 0;
      run_cnt_o = 0;
      exp_node  = 0;
    end else begin
      if (out_vld_i && exp_node >= `GNN_NUM_NODES) begin
        $display("Fail %0t: extra output for node %0d in one run", $time, out_node_i);
        err_cnt_o++;
      end else if (out_vld_i) begin
        exp_val = ref_output(exp_node);
        if (int'(out_node_i) != exp_node) begin
          $display("Fail %0t: output node %0d, expected node %0d", $time, out_node_i, exp_node);
          err_cnt_o++;
        end
        if (int'(out_data_i) != exp_val) begin
          $display("Fail %0t: node %0d output %0d, expected %0d",
                   $time, exp_node, out_data_i, exp_val);
          err_cnt_o++;
        end
        exp_node++;
      end
      if (done_i) begin
        if (exp_node != `GNN_NUM_NODES) begin
          $display("Fail %0t: run ended after %0d outputs, expected %0d",
                   $time, exp_node, `GNN_NUM_NODES);
          err_cnt_o++;
        end
        if (int'($signed(dbg_hid_i)) != ref_projection(`GNN_PROBE_NODE)) begin
          $display("Fail %0t: probe hidden %0d, expected %0d",
                   $time, $signed(dbg_hid_i), ref_projection(`GNN_PROBE_NODE));
          err_cnt_o++;
        end
        if (int'(dbg_out_i) != ref_output(`GNN_PROBE_NODE)) begin
          $display("Fail %0t: probe output %0d, expected %0d",
                   $time, dbg_out_i, ref_output(`GNN_PROBE_NODE));
          err_cnt_o++;
        end
        exp_node = 0;
        run_cnt_o++;
      end
    end
  end

endmodule

// File: dv/gat_asserts.sv
`timescale 1ns/1ps

module gat_asserts (
  input logic clk,
  input logic rst_n,
  input logic dmvm_start_i,
  input logic spmm_start_i,
  input logic busy_i,
  input logic done_i
);

  a_dmvm_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    dmvm_start_i |=> !dmvm_start_i)
    else $error("dmvm_start high for more than one cycle");

  a_spmm_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    spmm_start_i |=> !spmm_start_i)
    else $error("spmm_start high for more than one cycle");

  a_starts_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmvm_start_i && spmm_start_i))
    else $error("dmvm_start and spmm_start high together");

  a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> $past(busy_i))
    else $error("done_o without busy_o in the cycle before");

endmodule

bind gat_scheduler gat_asserts u_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .dmvm_start_i (ctl.dmvm_start),
  .spmm_start_i (ctl.spmm_start),
  .busy_i       (busy_o),
  .done_i       (done_o)
);

// File: dv/tb_gat_core.sv
`timescale 1ns/1ps
`include "gnn_config.svh"

module tb_gat_core;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        start_i;
  logic        wr_en_i;
  logic [1:0]  wr_sel_i;
  logic [2:0]  wr_addr_i;
  logic [31:0] wr_data_i;
  logic        busy_o;
  logic        done_o;
  logic        out_vld_o;
  logic [2:0]  out_node_o;
  logic [15:0] out_data_o;
  logic [3:0]  dbg_flags_o;
  logic [15:0] dbg_count_o;
  logic [17:0] dbg_hid_o;
  logic [15:0] dbg_out_o;
  int          seed;
  int          tb_err_cnt = 0;
  int          timeout_cnt = 0;
  int          chk_err_cnt;
  int          chk_run_cnt;

  always #5 clk = ~clk;

  gat_core dut_i (.*);

  gat_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en_i    (wr_en_i),
    .wr_sel_i   (wr_sel_i),
    .wr_addr_i  (wr_addr_i),
    .wr_data_i  (wr_data_i),
    .out_vld_i  (out_vld_o),
    .out_node_i (out_node_o),
    .out_data_i (out_data_o),
    .done_i     (done_o),
    .dbg_hid_i  (dbg_hid_o),
    .dbg_out_i  (dbg_out_o),
    .err_cnt_o  (chk_err_cnt),
    .run_cnt_o  (chk_run_cnt)
  );

  task automatic expect_equal(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
      tb_err_cnt++;
    end
  endtask

  task automatic host_write(input logic [1:0] sel, input logic [2:0] addr,
                            input logic [31:0] data);
    @(posedge clk);
    wr_en_i   <= 1'b1;
    wr_sel_i  <= sel;
    wr_addr_i <= addr;
    wr_data_i <= data;
  endtask

  // extreme: nodes 0..3 large positive, 4..7 large negative
  task automatic load_graph(input bit extreme);
    logic [31:0] word;
    for (int n = 0; n < `GNN_NUM_NODES; n++) begin
      word = $random(seed);
      if (extreme) word = (n < 4) ? 32'h7f7f_7f7f : 32'h8080_8080;
      host_write(gnn_pkg::WR_FEAT, 3'(n), word);
    end
    for (int n = 0; n < `GNN_NUM_NODES; n++) begin
      word = $random(seed);
      if (extreme && n == 0) word = 32'h0f;  // saturates
      if (extreme && n == 1) word = 32'hf0;  // relu to zero
      host_write(gnn_pkg::WR_ADJ, 3'(n), word);
    end
    word = extreme ? 32'h7f7f_7f7f : $random(seed);
    host_write(gnn_pkg::WR_WGT, 3'd0, word);
    @(posedge clk);
    wr_en_i <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  task automatic wait_busy(input logic level, input int limit, input string what,
                           output bit ok);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (busy_o !== level && n < limit);
    ok = (busy_o === level);
    if (!ok) begin
      $display("Timeout after %0d cycles while %s", limit, what);
      timeout_cnt++;
    end
  endtask

  task automatic run_graph(input bit extreme, input int run_no, output bit ok);
    load_graph(extreme);
    pulse_start();
    wait_busy(1'b1, 20, "waiting for busy_o to rise after start_i", ok);
    if (!ok) return;
    pulse_start();  // must be ignored
    wait_busy(1'b0, 500, "waiting for busy_o to fall at the end of a run", ok);
    if (!ok) return;
    repeat (20) @(negedge clk);
    expect_equal("busy_o after the run", busy_o, 0);
    expect_equal("dbg_count_o", dbg_count_o, 8 * run_no);
    expect_equal("done_o pulse count", chk_run_cnt, run_no);
  endtask

  initial begin
    bit ok;
    seed = 32'h6d121c7a;
    rst_n     <= 1'b0;
    start_i   <= 1'b0;
    wr_en_i   <= 1'b0;
    wr_sel_i  <= '0;
    wr_addr_i <= '0;
    wr_data_i <= '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_equal("busy_o after reset", busy_o, 0);
    expect_equal("done_o after reset", done_o, 0);
    expect_equal("out_vld_o after reset", out_vld_o, 0);
    expect_equal("dbg_flags_o after reset", dbg_flags_o, 0);
    expect_equal("dbg_count_o after reset", dbg_count_o, 0);
    run_graph(1'b0, 1, ok);
    if (ok) run_graph(1'b1, 2, ok);
    if (ok) expect_equal("dbg_flags_o after two runs", dbg_flags_o, 4'hf);
    $display("errors: testbench %0d, checker %0d, timeouts %0d",
             tb_err_cnt, chk_err_cnt, timeout_cnt);
    if (tb_err_cnt == 0 && chk_err_cnt == 0 && timeout_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+common
common/gnn_pkg.sv
common/stage_ctl_if.sv
source/node_ram.sv
source/gat_scheduler.sv
dmvm/dmvm_unit.sv
spmm/spmm_unit.sv
source/gnn_debugger.sv
source/gat_core.sv
dv/gat_checker.sv
dv/gat_asserts.sv
dv/tb_gat_core.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -f tb.f --top-module tb_gat_core -o sim_gat \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_gat)
echo "$out"
echo "$out" | grep -q "^Regression passed$" && exit 0 || exit 1
